// File: src/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef logic [6:0] opcode_t;   // major opcode field of the instruction
    typedef logic [1:0] alu_op_t;   // alu function select

    localparam opcode_t op_reg_code    = 7'b0110011;
    localparam opcode_t op_load_code   = 7'b0000011;
    localparam opcode_t op_imm_code    = 7'b0010011;
    localparam opcode_t op_fence_code  = 7'b0001111;
    localparam opcode_t op_store_code  = 7'b0100011;
    localparam opcode_t op_branch_code = 7'b1100011;
    localparam opcode_t op_lui_code    = 7'b0110111;
    localparam opcode_t op_jal_code    = 7'b1101111;
    localparam opcode_t op_jalr_code   = 7'b1100111;
    localparam opcode_t op_auipc_code  = 7'b0010111;
    localparam opcode_t op_system_code = 7'b1110011;

    localparam alu_op_t alu_add_pass = 2'b00;   // add or pass through
    localparam alu_op_t alu_branch   = 2'b01;   // compare for branch
    localparam alu_op_t alu_func     = 2'b10;   // function from funct fields

    // encodings visible on the state output
    typedef enum logic [3:0] {
        st_init             = 4'd0,
        st_fetch            = 4'd1,
        st_decode           = 4'd2,
        st_execute          = 4'd3,
        st_mem              = 4'd4,
        st_writeback        = 4'd5,
        st_branch_pause     = 4'd6,
        st_branch_pause_end = 4'd7,
        st_halt             = 4'd11
    } state_t;

    typedef enum logic [3:0] {
        cls_reg,
        cls_load,
        cls_imm,        // fence lands here as well
        cls_store,
        cls_branch,
        cls_lui,
        cls_jal,
        cls_jalr,
        cls_auipc,
        cls_system,
        cls_other
    } op_class_t;

endpackage

`default_nettype wire

// File: src/ctrl_word_if.sv
`default_nettype none

interface ctrl_word_if;

    logic               pc_s;
    logic               pc_we;
    logic               instr_rd;
    logic               regfile_s;
    logic               regfile_we;
    logic               imm_op;
    logic               alu_s1;
    logic               alu_s2;
    ctrl_pkg::alu_op_t  alu_op;
    logic               datamem_rd;
    logic               data_op;
    logic               data_s;
    logic               data_we;
    logic               bc_op;

    modport source (
        output pc_s, pc_we, instr_rd, regfile_s, regfile_we, imm_op, alu_s1, alu_s2,
               alu_op, datamem_rd, data_op, data_s, data_we, bc_op
    );

    modport sink (
        input pc_s, pc_we, instr_rd, regfile_s, regfile_we, imm_op, alu_s1, alu_s2,
              alu_op, datamem_rd, data_op, data_s, data_we, bc_op
    );

endinterface

`default_nettype wire

// File: src/opcode_classifier.sv
`default_nettype none

module opcode_classifier (
    input  ctrl_pkg::opcode_t   opcode,
    output ctrl_pkg::op_class_t op_class
);

    always_comb begin
        case (opcode)
            ctrl_pkg::op_reg_code:    op_class = ctrl_pkg::cls_reg;
            ctrl_pkg::op_load_code:   op_class = ctrl_pkg::cls_load;
            ctrl_pkg::op_imm_code:    op_class = ctrl_pkg::cls_imm;
            ctrl_pkg::op_fence_code:  op_class = ctrl_pkg::cls_imm;  // same flow as addi
            ctrl_pkg::op_store_code:  op_class = ctrl_pkg::cls_store;
            ctrl_pkg::op_branch_code: op_class = ctrl_pkg::cls_branch;
            ctrl_pkg::op_lui_code:    op_class = ctrl_pkg::cls_lui;
            ctrl_pkg::op_jal_code:    op_class = ctrl_pkg::cls_jal;
            ctrl_pkg::op_jalr_code:   op_class = ctrl_pkg::cls_jalr;
            ctrl_pkg::op_auipc_code:  op_class = ctrl_pkg::cls_auipc;
            ctrl_pkg::op_system_code: op_class = ctrl_pkg::cls_system;
            default:                  op_class = ctrl_pkg::cls_other;
        endcase
    end

endmodule

`default_nettype wire

// File: src/phase_sequencer.sv
`default_nettype none

module phase_sequencer (
    input  logic                clk,
    input  logic                rst,
    input  ctrl_pkg::op_class_t op_class,
    output ctrl_pkg::state_t    state
);

    ctrl_pkg::state_t state_nxt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= ctrl_pkg::st_init;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        case (state)
            ctrl_pkg::st_init:      state_nxt = ctrl_pkg::st_fetch;
            ctrl_pkg::st_fetch:     state_nxt = ctrl_pkg::st_decode;
            ctrl_pkg::st_decode: begin
                if (op_class == ctrl_pkg::cls_system) begin
                    state_nxt = ctrl_pkg::st_halt;      // ecall/ebreak stop the core
                end else begin
                    state_nxt = ctrl_pkg::st_execute;
                end
            end
            ctrl_pkg::st_execute:   state_nxt = ctrl_pkg::st_mem;
            ctrl_pkg::st_mem:       state_nxt = ctrl_pkg::st_writeback;
            ctrl_pkg::st_writeback: begin
                if (op_class == ctrl_pkg::cls_branch) begin
                    state_nxt = ctrl_pkg::st_branch_pause;  // give bc time to settle
                end else begin
                    state_nxt = ctrl_pkg::st_fetch;
                end
            end
            ctrl_pkg::st_branch_pause:     state_nxt = ctrl_pkg::st_branch_pause_end;
            ctrl_pkg::st_branch_pause_end: state_nxt = ctrl_pkg::st_fetch;
            ctrl_pkg::st_halt:             state_nxt = ctrl_pkg::st_halt;  // only reset leaves
            default:                       state_nxt = ctrl_pkg::st_init;
        endcase
    end

endmodule

`default_nettype wire

// File: src/control_word_gen.sv
`default_nettype none

module control_word_gen (
    input  logic                clk,
    input  logic                rst,
    input  ctrl_pkg::state_t    state,
    input  ctrl_pkg::op_class_t op_class,
    input  logic                bc,
    ctrl_word_if.source         word
);

    logic              pc_s_nxt;
    logic              pc_we_nxt;
    logic              instr_rd_nxt;
    logic              regfile_s_nxt;
    logic              regfile_we_nxt;
    logic              imm_op_nxt;
    logic              alu_s1_nxt;
    logic              alu_s2_nxt;
    ctrl_pkg::alu_op_t alu_op_nxt;
    logic              datamem_rd_nxt;
    logic              data_op_nxt;
    logic              data_s_nxt;
    logic              data_we_nxt;
    logic              bc_op_nxt;

    // every table field defaults to zero
    always_comb begin
        pc_s_nxt       = 1'b0;
        pc_we_nxt      = 1'b0;
        instr_rd_nxt   = 1'b0;
        regfile_s_nxt  = 1'b0;
        regfile_we_nxt = 1'b0;
        imm_op_nxt     = 1'b0;
        alu_s1_nxt     = 1'b0;
        alu_s2_nxt     = 1'b0;
        alu_op_nxt     = ctrl_pkg::alu_add_pass;
        datamem_rd_nxt = 1'b0;
        data_op_nxt    = 1'b0;
        data_s_nxt     = 1'b0;
        data_we_nxt    = 1'b0;
        bc_op_nxt      = 1'b0;

        case (state)
            ctrl_pkg::st_init, ctrl_pkg::st_fetch, ctrl_pkg::st_decode: begin
                instr_rd_nxt = 1'b1;                // read instruction memory
            end
            ctrl_pkg::st_branch_pause_end: begin
                pc_we_nxt  = 1'b1;
                pc_s_nxt   = bc;                    // taken branch picks alu target
                data_s_nxt = bc;
            end
            ctrl_pkg::st_execute: begin
                case (op_class)
                    ctrl_pkg::cls_reg: begin
                        alu_s2_nxt = 1'b1;          // rs2 into alu
                        alu_op_nxt = ctrl_pkg::alu_func;
                        data_s_nxt = 1'b1;
                    end
                    ctrl_pkg::cls_load, ctrl_pkg::cls_imm: begin
                        imm_op_nxt     = 1'b1;
                        datamem_rd_nxt = 1'b1;
                        data_op_nxt    = 1'b1;      // sign extend loaded data
                    end
                    ctrl_pkg::cls_store: begin
                        pc_s_nxt       = 1'b1;
                        imm_op_nxt     = 1'b1;
                        datamem_rd_nxt = 1'b1;
                        data_op_nxt    = 1'b1;
                    end
                    ctrl_pkg::cls_branch: begin
                        alu_s2_nxt = 1'b1;
                        alu_op_nxt = ctrl_pkg::alu_branch;
                        bc_op_nxt  = 1'b1;          // evaluate branch condition
                    end
                    ctrl_pkg::cls_lui: begin
                        imm_op_nxt     = 1'b1;
                        datamem_rd_nxt = 1'b1;
                    end
                    ctrl_pkg::cls_jal: begin
                        regfile_we_nxt = 1'b1;      // link pc + 4 into rd
                        imm_op_nxt     = 1'b1;
                        alu_s1_nxt     = 1'b1;      // pc as first operand
                        alu_op_nxt     = ctrl_pkg::alu_func;
                    end
                    ctrl_pkg::cls_jalr: begin
                        regfile_s_nxt = 1'b1;
                        imm_op_nxt    = 1'b1;
                        alu_op_nxt    = ctrl_pkg::alu_func;
                    end
                    ctrl_pkg::cls_auipc: begin
                        imm_op_nxt = 1'b1;
                        alu_s1_nxt = 1'b1;
                        alu_op_nxt = ctrl_pkg::alu_func;
                    end
                    default: ;
                endcase
            end
            ctrl_pkg::st_mem: begin
                case (op_class)
                    ctrl_pkg::cls_reg: begin
                        alu_s2_nxt = 1'b1;
                        data_s_nxt = 1'b1;          // keep alu result on the data path
                    end
                    ctrl_pkg::cls_imm: begin
                        data_s_nxt = 1'b1;
                    end
                    ctrl_pkg::cls_branch: begin
                        alu_s2_nxt = 1'b1;
                        alu_op_nxt = ctrl_pkg::alu_branch;
                        bc_op_nxt  = 1'b1;
                    end
                    ctrl_pkg::cls_lui: begin
                        pc_s_nxt   = 1'b1;
                        data_s_nxt = 1'b1;
                    end
                    ctrl_pkg::cls_auipc: begin
                        imm_op_nxt = 1'b1;
                        alu_s1_nxt = 1'b1;
                        alu_op_nxt = ctrl_pkg::alu_func;
                        data_s_nxt = 1'b1;
                    end
                    default: ;                      // load, store, jal, jalr idle
                endcase
            end
            ctrl_pkg::st_writeback: begin
                case (op_class)
                    ctrl_pkg::cls_reg: begin
                        pc_we_nxt      = 1'b1;
                        regfile_s_nxt  = 1'b1;
                        regfile_we_nxt = 1'b1;
                        alu_s2_nxt     = 1'b1;
                        data_s_nxt     = 1'b1;
                    end
                    ctrl_pkg::cls_load: begin
                        pc_we_nxt      = 1'b1;
                        regfile_s_nxt  = 1'b1;
                        regfile_we_nxt = 1'b1;      // memory data into rd
                    end
                    ctrl_pkg::cls_imm, ctrl_pkg::cls_lui: begin
                        pc_we_nxt      = 1'b1;
                        regfile_s_nxt  = 1'b1;
                        regfile_we_nxt = 1'b1;
                        data_s_nxt     = 1'b1;
                    end
                    ctrl_pkg::cls_store: begin
                        pc_we_nxt   = 1'b1;
                        data_we_nxt = 1'b1;         // commit the store
                    end
                    ctrl_pkg::cls_branch: begin
                        pc_s_nxt   = bc;
                        alu_op_nxt = ctrl_pkg::alu_branch;
                        data_s_nxt = bc;
                    end
                    ctrl_pkg::cls_jal: begin
                        pc_s_nxt       = 1'b1;      // jump target from alu
                        pc_we_nxt      = 1'b1;
                        regfile_we_nxt = 1'b1;
                    end
                    ctrl_pkg::cls_jalr: begin
                        pc_s_nxt       = 1'b1;
                        pc_we_nxt      = 1'b1;
                        regfile_s_nxt  = 1'b1;
                        regfile_we_nxt = 1'b1;
                        data_s_nxt     = 1'b1;
                    end
                    ctrl_pkg::cls_auipc: begin
                        regfile_s_nxt  = 1'b1;
                        regfile_we_nxt = 1'b1;
                        imm_op_nxt     = 1'b1;
                        alu_s1_nxt     = 1'b1;
                        alu_op_nxt     = ctrl_pkg::alu_func;
                        data_s_nxt     = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;                              // pause and halt drive nothing
        endcase
    end

    // one register stage between table and outputs
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            word.pc_s       <= 1'b0;
            word.pc_we      <= 1'b0;
            word.instr_rd   <= 1'b0;
            word.regfile_s  <= 1'b0;
            word.regfile_we <= 1'b0;
            word.imm_op     <= 1'b0;
            word.alu_s1     <= 1'b0;
            word.alu_s2     <= 1'b0;
            word.alu_op     <= ctrl_pkg::alu_add_pass;
            word.datamem_rd <= 1'b0;
            word.data_op    <= 1'b0;
            word.data_s     <= 1'b0;
            word.data_we    <= 1'b0;
            word.bc_op      <= 1'b0;
        end else begin
            word.pc_s       <= pc_s_nxt;
            word.pc_we      <= pc_we_nxt;
            word.instr_rd   <= instr_rd_nxt;
            word.regfile_s  <= regfile_s_nxt;
            word.regfile_we <= regfile_we_nxt;
            word.imm_op     <= imm_op_nxt;
            word.alu_s1     <= alu_s1_nxt;
            word.alu_s2     <= alu_s2_nxt;
            word.alu_op     <= alu_op_nxt;
            word.datamem_rd <= datamem_rd_nxt;
            word.data_op    <= data_op_nxt;
            word.data_s     <= data_s_nxt;
            word.data_we    <= data_we_nxt;
            word.bc_op      <= bc_op_nxt;
        end
    end

endmodule

`default_nettype wire

// File: src/control_unit.sv
`default_nettype none

module control_unit (
    input  logic              clk,
    input  logic              rst,
    input  ctrl_pkg::opcode_t opcode,
    input  logic              bc,            // branch condition from the alu
    output logic              pc_s,
    output logic              pc_we,
    output logic              instr_rd,
    output logic              regfile_s,
    output logic              regfile_we,
    output logic              imm_op,
    output logic              alu_s1,
    output logic              alu_s2,
    output logic              datamem_rd,
    output logic              data_op,
    output logic              data_s,
    output logic              data_we,
    output logic              bc_op,
    output ctrl_pkg::alu_op_t alu_op,
    output ctrl_pkg::state_t  state
);

    ctrl_pkg::op_class_t op_class;

    ctrl_word_if u_word ();

    opcode_classifier u_classifier (
        .opcode   (opcode),
        .op_class (op_class)
    );

    phase_sequencer u_sequencer (
        .clk      (clk),
        .rst      (rst),
        .op_class (op_class),
        .state    (state)
    );

    control_word_gen u_word_gen (
        .clk      (clk),
        .rst      (rst),
        .state    (state),
        .op_class (op_class),
        .bc       (bc),
        .word     (u_word.source)
    );

    assign pc_s       = u_word.pc_s;
    assign pc_we      = u_word.pc_we;
    assign instr_rd   = u_word.instr_rd;
    assign regfile_s  = u_word.regfile_s;
    assign regfile_we = u_word.regfile_we;
    assign imm_op     = u_word.imm_op;
    assign alu_s1     = u_word.alu_s1;
    assign alu_s2     = u_word.alu_s2;
    assign alu_op     = u_word.alu_op;
    assign datamem_rd = u_word.datamem_rd;
    assign data_op    = u_word.data_op;
    assign data_s     = u_word.data_s;
    assign data_we    = u_word.data_we;
    assign bc_op      = u_word.bc_op;

endmodule

`default_nettype wire

// File: tb/control_model.svh
`ifndef CONTROL_MODEL_SVH
`define CONTROL_MODEL_SVH

// expected word in the field order of the output ports
typedef struct packed {
    logic              pc_s;
    logic              pc_we;
    logic              instr_rd;
    logic              regfile_s;
    logic              regfile_we;
    logic              imm_op;
    logic              alu_s1;
    logic              alu_s2;
    ctrl_pkg::alu_op_t alu_op;
    logic              datamem_rd;
    logic              data_op;
    logic              data_s;
    logic              data_we;
    logic              bc_op;
} exp_word_t;

ctrl_pkg::state_t m_state;      // model phase
exp_word_t        m_word;       // model of the registered word

function automatic ctrl_pkg::op_class_t model_class(input ctrl_pkg::opcode_t code);
    case (code)
        ctrl_pkg::op_reg_code:    return ctrl_pkg::cls_reg;
        ctrl_pkg::op_load_code:   return ctrl_pkg::cls_load;
        ctrl_pkg::op_imm_code:    return ctrl_pkg::cls_imm;
        ctrl_pkg::op_fence_code:  return ctrl_pkg::cls_imm;
        ctrl_pkg::op_store_code:  return ctrl_pkg::cls_store;
        ctrl_pkg::op_branch_code: return ctrl_pkg::cls_branch;
        ctrl_pkg::op_lui_code:    return ctrl_pkg::cls_lui;
        ctrl_pkg::op_jal_code:    return ctrl_pkg::cls_jal;
        ctrl_pkg::op_jalr_code:   return ctrl_pkg::cls_jalr;
        ctrl_pkg::op_auipc_code:  return ctrl_pkg::cls_auipc;
        ctrl_pkg::op_system_code: return ctrl_pkg::cls_system;
        default:                  return ctrl_pkg::cls_other;
    endcase
endfunction

function automatic ctrl_pkg::state_t model_next(input ctrl_pkg::state_t ph,
                                                input ctrl_pkg::op_class_t cls);
    case (ph)
        ctrl_pkg::st_init:             return ctrl_pkg::st_fetch;
        ctrl_pkg::st_fetch:            return ctrl_pkg::st_decode;
        ctrl_pkg::st_decode:
            return (cls == ctrl_pkg::cls_system) ? ctrl_pkg::st_halt : ctrl_pkg::st_execute;
        ctrl_pkg::st_execute:          return ctrl_pkg::st_mem;
        ctrl_pkg::st_mem:              return ctrl_pkg::st_writeback;
        ctrl_pkg::st_writeback:
            return (cls == ctrl_pkg::cls_branch) ? ctrl_pkg::st_branch_pause
                                                 : ctrl_pkg::st_fetch;
        ctrl_pkg::st_branch_pause:     return ctrl_pkg::st_branch_pause_end;
        ctrl_pkg::st_branch_pause_end: return ctrl_pkg::st_fetch;
        default:                       return ph;   // halt holds
    endcase
endfunction

// bit columns ps pw ir rs rw io a1 a2 aop dr do ds dw bo
function automatic exp_word_t model_entry(input ctrl_pkg::state_t ph,
                                          input ctrl_pkg::op_class_t cls,
                                          input logic bcv);
    exp_word_t w;
    w = '0;
    case (ph)
        ctrl_pkg::st_init, ctrl_pkg::st_fetch, ctrl_pkg::st_decode:
            w = 15'b0_0_1_0_0_0_0_0_00_0_0_0_0_0;
        ctrl_pkg::st_branch_pause_end: begin
            w        = 15'b0_1_0_0_0_0_0_0_00_0_0_0_0_0;
            w.pc_s   = bcv;
            w.data_s = bcv;
        end
        ctrl_pkg::st_execute:
            case (cls)
                ctrl_pkg::cls_reg:    w = 15'b0_0_0_0_0_0_0_1_10_0_0_1_0_0;
                ctrl_pkg::cls_load:   w = 15'b0_0_0_0_0_1_0_0_00_1_1_0_0_0;
                ctrl_pkg::cls_imm:    w = 15'b0_0_0_0_0_1_0_0_00_1_1_0_0_0;
                ctrl_pkg::cls_store:  w = 15'b1_0_0_0_0_1_0_0_00_1_1_0_0_0;
                ctrl_pkg::cls_branch: w = 15'b0_0_0_0_0_0_0_1_01_0_0_0_0_1;
                ctrl_pkg::cls_lui:    w = 15'b0_0_0_0_0_1_0_0_00_1_0_0_0_0;
                ctrl_pkg::cls_jal:    w = 15'b0_0_0_0_1_1_1_0_10_0_0_0_0_0;
                ctrl_pkg::cls_jalr:   w = 15'b0_0_0_1_0_1_0_0_10_0_0_0_0_0;
                ctrl_pkg::cls_auipc:  w = 15'b0_0_0_0_0_1_1_0_10_0_0_0_0_0;
                default:              w = '0;
            endcase
        ctrl_pkg::st_mem:
            case (cls)
                ctrl_pkg::cls_reg:    w = 15'b0_0_0_0_0_0_0_1_00_0_0_1_0_0;
                ctrl_pkg::cls_imm:    w = 15'b0_0_0_0_0_0_0_0_00_0_0_1_0_0;
                ctrl_pkg::cls_branch: w = 15'b0_0_0_0_0_0_0_1_01_0_0_0_0_1;
                ctrl_pkg::cls_lui:    w = 15'b1_0_0_0_0_0_0_0_00_0_0_1_0_0;
                ctrl_pkg::cls_auipc:  w = 15'b0_0_0_0_0_1_1_0_10_0_0_1_0_0;
                default:              w = '0;
            endcase
        ctrl_pkg::st_writeback:
            case (cls)
                ctrl_pkg::cls_reg:    w = 15'b0_1_0_1_1_0_0_1_00_0_0_1_0_0;
                ctrl_pkg::cls_load:   w = 15'b0_1_0_1_1_0_0_0_00_0_0_0_0_0;
                ctrl_pkg::cls_imm:    w = 15'b0_1_0_1_1_0_0_0_00_0_0_1_0_0;
                ctrl_pkg::cls_lui:    w = 15'b0_1_0_1_1_0_0_0_00_0_0_1_0_0;
                ctrl_pkg::cls_store:  w = 15'b0_1_0_0_0_0_0_0_00_0_0_0_1_0;
                ctrl_pkg::cls_branch: begin
                    w        = 15'b0_0_0_0_0_0_0_0_01_0_0_0_0_0;
                    w.pc_s   = bcv;
                    w.data_s = bcv;
                end
                ctrl_pkg::cls_jal:    w = 15'b1_1_0_0_1_0_0_0_00_0_0_0_0_0;
                ctrl_pkg::cls_jalr:   w = 15'b1_1_0_1_1_0_0_0_00_0_0_1_0_0;
                ctrl_pkg::cls_auipc:  w = 15'b0_0_0_1_1_1_1_0_10_0_0_1_0_0;
                default:              w = '0;
            endcase
        default: w = '0;                        // pause and halt
    endcase
    return w;
endfunction

task automatic model_reset();
    m_state = ctrl_pkg::st_init;
    m_word  = '0;
endtask

// one clock edge with the word taken from the phase before it
task automatic model_step(input ctrl_pkg::opcode_t code, input logic bcv);
    ctrl_pkg::op_class_t cls;
    cls     = model_class(code);
    m_word  = model_entry(m_state, cls, bcv);
    m_state = model_next(m_state, cls);
endtask

`endif

// File: tb/tb_control_unit.sv
`default_nettype none

module tb_control_unit;

    timeunit 1ns;
    timeprecision 1ps;

    logic              clk;
    logic              rst;
    ctrl_pkg::opcode_t opcode;
    logic              bc;
    logic              pc_s;
    logic              pc_we;
    logic              instr_rd;
    logic              regfile_s;
    logic              regfile_we;
    logic              imm_op;
    logic              alu_s1;
    logic              alu_s2;
    logic              datamem_rd;
    logic              data_op;
    logic              data_s;
    logic              data_we;
    logic              bc_op;
    ctrl_pkg::alu_op_t alu_op;
    ctrl_pkg::state_t  state;

    int unsigned cycle;
    int unsigned state_errors;
    int unsigned bit_errors;
    int unsigned alu_errors;
    bit          timed_out;

    `include "control_model.svh"

    control_unit u_dut (
        .clk        (clk),
        .rst        (rst),
        .opcode     (opcode),
        .bc         (bc),
        .pc_s       (pc_s),
        .pc_we      (pc_we),
        .instr_rd   (instr_rd),
        .regfile_s  (regfile_s),
        .regfile_we (regfile_we),
        .imm_op     (imm_op),
        .alu_s1     (alu_s1),
        .alu_s2     (alu_s2),
        .datamem_rd (datamem_rd),
        .data_op    (data_op),
        .data_s     (data_s),
        .data_we    (data_we),
        .bc_op      (bc_op),
        .alu_op     (alu_op),
        .state      (state)
    );

    always #50 clk = ~clk;

    task automatic check_state(input string name, input ctrl_pkg::state_t exp,
                               input ctrl_pkg::state_t act);
        if (act !== exp) begin
            state_errors++;
            $display("Error %s at cycle %0d: expected %s (%0d), actual %s (%0d)",
                     name, cycle, exp.name(), exp, act.name(), act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            bit_errors++;
            $display("Error %s at cycle %0d: expected %b, actual %b", name, cycle, exp, act);
        end
    endtask

    task automatic check_alu_op(input string name, input ctrl_pkg::alu_op_t exp,
                                input ctrl_pkg::alu_op_t act);
        if (act !== exp) begin
            alu_errors++;
            $display("Error %s at cycle %0d: expected %b, actual %b", name, cycle, exp, act);
        end
    endtask

    task automatic compare_outputs();
        check_state("state", m_state, state);
        check_bit("pc_s", m_word.pc_s, pc_s);
        check_bit("pc_we", m_word.pc_we, pc_we);
        check_bit("instr_rd", m_word.instr_rd, instr_rd);
        check_bit("regfile_s", m_word.regfile_s, regfile_s);
        check_bit("regfile_we", m_word.regfile_we, regfile_we);
        check_bit("imm_op", m_word.imm_op, imm_op);
        check_bit("alu_s1", m_word.alu_s1, alu_s1);
        check_bit("alu_s2", m_word.alu_s2, alu_s2);
        check_bit("datamem_rd", m_word.datamem_rd, datamem_rd);
        check_bit("data_op", m_word.data_op, data_op);
        check_bit("data_s", m_word.data_s, data_s);
        check_bit("data_we", m_word.data_we, data_we);
        check_bit("bc_op", m_word.bc_op, bc_op);
        check_alu_op("alu_op", m_word.alu_op, alu_op);
    endtask

    // mostly valid codes, some random ones, system now and then
    function automatic ctrl_pkg::opcode_t pick_opcode();
        int unsigned sel;
        logic [31:0] raw;
        sel = $urandom % 40;
        raw = $urandom;
        if (sel == 0) begin
            return ctrl_pkg::op_system_code;
        end
        if (sel < 5) begin
            return raw[6:0];
        end
        case ((sel - 5) % 10)
            0:       return ctrl_pkg::op_reg_code;
            1:       return ctrl_pkg::op_load_code;
            2:       return ctrl_pkg::op_imm_code;
            3:       return ctrl_pkg::op_fence_code;
            4:       return ctrl_pkg::op_store_code;
            5:       return ctrl_pkg::op_branch_code;
            6:       return ctrl_pkg::op_lui_code;
            7:       return ctrl_pkg::op_jal_code;
            8:       return ctrl_pkg::op_jalr_code;
            default: return ctrl_pkg::op_auipc_code;
        endcase
    endfunction

    // advance the model, drive new inputs and check at the falling edge
    task automatic step_cycle(input logic rst_next);
        logic [31:0] rnd;
        @(posedge clk);
        if (!rst || !rst_next) begin
            model_reset();                      // async reset wins over the edge
        end else begin
            model_step(opcode, bc);
        end
        rnd = $urandom;
        rst    <= rst_next;
        opcode <= pick_opcode();
        bc     <= rnd[0];
        @(negedge clk);
        cycle++;
        compare_outputs();
    endtask

    task automatic apply_reset();
        repeat (3) step_cycle(1'b0);
        step_cycle(1'b1);
    endtask

    task automatic hold_in_halt();
        int unsigned waited;
        int unsigned settled;
        waited  = 0;
        settled = 0;
        while (settled < 4 && !timed_out) begin
            step_cycle(1'b1);
            if (state == ctrl_pkg::st_halt) begin
                settled++;
            end else begin
                settled = 0;
            end
            waited++;
            if (waited > 16) begin
                timed_out = 1'b1;
                $display("Timeout: state did not stay in halt within 16 cycles");
            end
        end
    endtask

    initial begin
        void'($urandom(90));
        clk          = 1'b0;
        rst          = 1'b0;
        opcode       = '0;
        bc           = 1'b0;
        cycle        = 0;
        state_errors = 0;
        bit_errors   = 0;
        alu_errors   = 0;
        timed_out    = 1'b0;
        model_reset();
        apply_reset();
        for (int i = 0; i < 3000; i++) begin
            step_cycle(1'b1);
            if (m_state == ctrl_pkg::st_halt) begin
                hold_in_halt();
                if (timed_out) begin
                    break;
                end
                apply_reset();                  // only way out of halt
            end
        end
        $display("Summary: %0d state errors, %0d control bit errors, %0d alu_op errors, %0d cycles",
                 state_errors, bit_errors, alu_errors, cycle);
        if (timed_out || (state_errors + bit_errors + alu_errors) != 0) begin
            $display("Verification failed");
        end else begin
            $display("Verification passed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: control_unit.f
+incdir+tb
src/ctrl_pkg.sv
src/ctrl_word_if.sv
src/opcode_classifier.sv
src/phase_sequencer.sv
src/control_word_gen.sv
src/control_unit.sv
tb/tb_control_unit.sv

// File: Makefile
BIN  := obj_dir/Vtb_control_unit
SRCS := $(wildcard src/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)

.PHONY: all run clean

all: run

$(BIN): control_unit.f $(SRCS)
	verilator --binary --timescale 1ns/1ps -f control_unit.f --top-module tb_control_unit

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q '^Verification passed$$'

clean:
	rm -rf obj_dir
